//--- compile.f
+incdir+design
+incdir+sim
design/soc_pkg.sv
design/sd_sector_capture.sv
design/sd_sector_buffer.sv
design/data_ram.sv
design/bus_target.sv
design/soc_top.sv
sim/tb_soc.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module tb_soc -o tb_soc_sim || exit 1
out=$(./obj_dir/tb_soc_sim)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

//--- sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// totals for the closing line
int check_count = 0;
int error_count = 0;

// 64-bit bus read data
task automatic check_data(input string name, input data_t got, input data_t expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
    end
endtask

// sector number register
task automatic check_addr(input string name, input sector_addr_t got,
                          input sector_addr_t expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
    end
endtask

// interrupt vector
task automatic check_irq(input string name, input irq_vec_t got, input irq_vec_t expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
    end
endtask

// single status lines
task automatic check_bit(input string name, input logic got, input logic expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("FAIL t=%0t %s got %b expected %b", $time, name, got, expected);
    end
endtask

// anything that is not a value mismatch
task automatic report_failure(input string what);
    error_count++;
    $display("ERROR t=%0t %s", $time, what);
endtask

`endif

//--- sim/tb_soc.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module tb_soc
    import soc_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    // RAM words under test are all written before the first load
    localparam int TEST_WORDS   = 64;
    // cycles a single bus access may take before it counts as stuck
    localparam int DONE_WAIT    = 16;
    // each test may take four times as long as the sector feed
    localparam int NUM_TESTS    = 5;
    localparam int LONGEST_TEST = `SDC_BYTES * 16;
    localparam int WATCHDOG_NS  = NUM_TESTS * LONGEST_TEST * CLK_PERIOD * 4;

    logic         CLOCK_50;
    logic         KEY0;
    addr_t        bus_address;
    data_t        bus_write_data;
    data_t        bus_read_data;
    logic         bus_read_enable;
    logic         bus_write_enable;
    logic         bus_read_done;
    logic         bus_write_done;
    access_size_e bus_read_type;
    access_size_e bus_write_type;
    byte_t        key_ascii;
    logic         key_pressed;
    logic         irq_ack;
    irq_vec_t     irq_vector;
    byte_t        sd_dout;
    logic         sd_byte_available;
    logic         sd_ready;
    logic         sd_rd_start;
    sector_addr_t sd_sector_addr;

    // model of the RAM test region bytes, the sector bytes and the interrupt state
    byte_t        ram_image [0:4*TEST_WORDS-1];
    byte_t        sector_image [0:`SDC_BYTES-1];
    irq_vec_t     exp_irq;
    int           rd_start_pulses = 0;
    access_size_e load_sizes [0:5] = '{size_b, size_h, size_w, size_bu, size_hu, size_wu};

    `include "tb_checks.svh"

    soc_top UUT (.*);

    always #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

    // pulse counter sampled on the falling edge
    always @(negedge CLOCK_50) begin
        if (sd_rd_start) rd_start_pulses++;
    end

    // a size unlike the given one for the idle direction
    function automatic access_size_e other_size(input access_size_e size);
        return (size == size_d) ? size_b : size_d;
    endfunction

    // one access raises its enable for a cycle and then waits for done
    task automatic bus_access(input logic write, input addr_t addr, input access_size_e size,
                              input data_t wdata, output data_t rdata);
        int waited;
        waited = 0;
        @(negedge CLOCK_50);
        bus_address = addr;
        bus_read_type = write ? other_size(size) : size;
        bus_write_type = write ? size : other_size(size);
        bus_write_data = wdata;
        if (write) bus_write_enable = 1'b1;
        else bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        bus_read_enable = 1'b0;
        // done fell on the enable edge
        while (!(write ? bus_write_done : bus_read_done) && waited < DONE_WAIT) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (!(write ? bus_write_done : bus_read_done)) begin
            report_failure($sformatf("bus access at address %h never completed", addr));
        end
        rdata = bus_read_data;
    endtask

    task automatic bus_write(input addr_t addr, input access_size_e size, input data_t wdata);
        data_t ignored;
        bus_access(1'b1, addr, size, wdata, ignored);
    endtask

    task automatic bus_read(input addr_t addr, input access_size_e size, output data_t rdata);
        bus_access(1'b0, addr, size, '0, rdata);
    endtask

    function automatic int size_bytes(input access_size_e size);
        case (size)
            size_b, size_bu: return 1;
            size_h, size_hu: return 2;
            size_d:          return 8;
            default:         return 4;
        endcase
    endfunction

    // little endian word from the byte image
    function automatic word_t image_word(input int word);
        return {ram_image[4*word+3], ram_image[4*word+2], ram_image[4*word+1], ram_image[4*word]};
    endfunction

    // whole word moved down by the byte offset with upper bits zero
    function automatic data_t expected_load(input int offset);
        return data_t'(image_word(offset / 4) >> (8 * (offset % 4)));
    endfunction

    function automatic logic is_mapped(input addr_t addr);
        return (addr >= `RAM_BASE && addr < `RAM_BASE + 4 * `RAM_WORDS)
            || addr == `KEY_ADDR || addr == `SDC_ADDR_REG || addr == `SDC_READ_REG
            || addr == `SDC_READY_REG || addr == `SDC_AVAIL_REG
            || (addr >= `SDC_BASE && addr < `SDC_BASE + `SDC_BYTES);
    endfunction

    task automatic ram_store(input int offset, input access_size_e size, input data_t value);
        bus_write(`RAM_BASE + addr_t'(offset), size, value);
        for (int i = 0; i < size_bytes(size); i++) begin
            ram_image[offset + i] = value[8*i +: 8];
        end
    endtask

    task automatic ram_load_check(input int offset, input access_size_e size);
        data_t got;
        bus_read(`RAM_BASE + addr_t'(offset), size, got);
        check_data("bus_read_data", got, expected_load(offset));
    endtask

    // press and ack held for one cycle where ack wins over a press
    task automatic key_cycle(input byte_t ascii, input logic press, input logic ack);
        @(negedge CLOCK_50);
        key_ascii = ascii;
        key_pressed = press;
        irq_ack = ack;
        if (ack && exp_irq != '0) exp_irq = '0;
        else if (press && ascii != '0) exp_irq = `IRQ_KEY;
        @(negedge CLOCK_50);
        key_pressed = 1'b0;
        irq_ack = 1'b0;
        check_irq("irq_vector", irq_vector, exp_irq);
    endtask

    // strobe high and low for one to three cycles each
    task automatic feed_sd_byte(input byte_t value);
        int high_cycles;
        int low_cycles;
        high_cycles = 1 + $urandom % 3;
        low_cycles = 1 + $urandom % 3;
        @(negedge CLOCK_50);
        sd_dout = value;
        sd_byte_available = 1'b1;
        repeat (high_cycles) @(negedge CLOCK_50);
        sd_byte_available = 1'b0;
        repeat (low_cycles - 1) @(negedge CLOCK_50);
    endtask

    task automatic end_test(input string name, input int errors_before);
        $display("test %-10s finished, %0d errors", name, error_count - errors_before);
    endtask

    task automatic narrow_ram_test();
        int errors_before;
        int offset;
        int pick;
        access_size_e size;
        errors_before = error_count;
        for (int w = 0; w < TEST_WORDS; w++) begin
            ram_store(4 * w, size_w, data_t'($urandom));
        end
        for (int n = 0; n < 200; n++) begin
            pick = $urandom % 3;
            offset = 4 * ($urandom % TEST_WORDS);
            case (pick)
                0: begin
                    size = size_b;
                    offset = offset + $urandom % 4;
                end
                // halves only on lane 0 or 2
                1: begin
                    size = size_h;
                    offset = offset + 2 * ($urandom % 2);
                end
                default: size = size_w;
            endcase
            ram_store(offset, size, {$urandom, $urandom});
            pick = $urandom % 6;
            ram_load_check(offset - offset % 4 + $urandom % 4, load_sizes[pick]);
            pick = $urandom % 6;
            ram_load_check($urandom % (4 * TEST_WORDS), load_sizes[pick]);
        end
        end_test("narrow_ram", errors_before);
    endtask

    task automatic doubleword_test();
        int errors_before;
        int word;
        data_t got;
        errors_before = error_count;
        for (int n = 0; n < 40; n++) begin
            word = $urandom % (TEST_WORDS - 1);
            ram_store(4 * word, size_d, {$urandom, $urandom});
            bus_read(`RAM_BASE + addr_t'(4 * word), size_d, got);
            check_data("bus_read_data", got, {image_word(word + 1), image_word(word)});
            // halves one word at a time
            ram_load_check(4 * word, size_w);
            ram_load_check(4 * word + 4, size_wu);
            // new upper word by a plain store and then the pair again
            ram_store(4 * word + 4, size_w, data_t'($urandom));
            bus_read(`RAM_BASE + addr_t'(4 * word), size_d, got);
            check_data("bus_read_data", got, {image_word(word + 1), image_word(word)});
        end
        end_test("doubleword", errors_before);
    endtask

    task automatic keyboard_test();
        int errors_before;
        byte_t ascii;
        data_t got;
        errors_before = error_count;
        // zero code raises nothing
        key_cycle(8'h00, 1'b1, 1'b0);
        for (int n = 0; n < 30; n++) begin
            ascii = byte_t'($urandom);
            key_ascii = ascii;
            bus_read(`KEY_ADDR, size_bu, got);
            check_data("key register", got, data_t'(ascii));
            // about a quarter of presses carry a zero code
            key_cycle((($urandom % 4) == 0) ? 8'h00 : ascii, 1'b1, 1'b0);
            key_cycle(byte_t'($urandom), ($urandom % 2) != 0, ($urandom % 3) != 0);
        end
        key_cycle(8'h00, 1'b0, 1'b1);
        end_test("keyboard", errors_before);
    endtask

    task automatic sector_test();
        int errors_before;
        int pulses_before;
        sector_addr_t sector;
        data_t got;
        errors_before = error_count;
        pulses_before = rd_start_pulses;
        sector = sector_addr_t'($urandom);
        bus_write(`SDC_ADDR_REG, size_w, {$urandom, sector});
        check_addr("sd_sector_addr", sd_sector_addr, sector);
        bus_write(`SDC_READ_REG, size_w, data_t'($urandom));
        repeat (4) @(negedge CLOCK_50);
        if (rd_start_pulses - pulses_before != 1) begin
            report_failure($sformatf("expected one sd_rd_start pulse, saw %0d",
                                     rd_start_pulses - pulses_before));
        end
        bus_read(`SDC_AVAIL_REG, size_wu, got);
        check_data("sector available", got, 64'd0);
        for (int i = 0; i < `SDC_BYTES; i++) begin
            sector_image[i] = byte_t'($urandom);
            feed_sd_byte(sector_image[i]);
        end
        bus_read(`SDC_AVAIL_REG, size_wu, got);
        check_data("sector available", got, 64'd1);
        for (int i = 0; i < `SDC_BYTES; i++) begin
            bus_read(`SDC_BASE + addr_t'(i), size_bu, got);
            check_data("sector buffer byte", got, data_t'(sector_image[i]));
        end
        // first byte of the next sector drops the flag
        feed_sd_byte(byte_t'($urandom));
        bus_read(`SDC_AVAIL_REG, size_wu, got);
        check_data("sector available", got, 64'd0);
        end_test("sector", errors_before);
    endtask

    task automatic status_test();
        int errors_before;
        int pick;
        addr_t addr;
        data_t got;
        errors_before = error_count;
        for (int n = 0; n < 10; n++) begin
            sd_ready = ($urandom % 2) != 0;
            bus_read(`SDC_READY_REG, size_wu, got);
            check_data("sd ready register", got, data_t'(sd_ready));
        end
        for (int n = 0; n < 40; n++) begin
            // even passes anywhere and odd passes in the gaps around the register block
            do begin
                if (n % 2 == 0) addr = addr_t'($urandom);
                else addr = addr_t'(32'h2000 + $urandom % 32'h2000);
            end while (is_mapped(addr));
            // RAM data on the bus first so a stale result shows
            ram_load_check($urandom % (4 * TEST_WORDS), size_w);
            pick = $urandom % 6;
            bus_read(addr, load_sizes[pick], got);
            check_data("unmapped read", got, 64'd0);
        end
        end_test("status", errors_before);
    endtask

    initial begin
        void'($urandom(30));
        CLOCK_50 = 1'b0;
        KEY0 = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        bus_read_type = size_w;
        bus_write_type = size_w;
        key_ascii = '0;
        key_pressed = 1'b0;
        irq_ack = 1'b0;
        sd_dout = '0;
        sd_byte_available = 1'b0;
        sd_ready = 1'b0;
        exp_irq = '0;
        repeat (RESET_CYCLES) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        // idle bus out of reset
        check_bit("bus_read_done", bus_read_done, 1'b1);
        check_bit("bus_write_done", bus_write_done, 1'b1);
        check_irq("irq_vector", irq_vector, exp_irq);
        check_addr("sd_sector_addr", sd_sector_addr, '0);
        narrow_ram_test();
        doubleword_test();
        keyboard_test();
        sector_test();
        status_test();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // hard stop if a test stalls
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_top
    import soc_pkg::*;
(
    input  wire                CLOCK_50,
    input  wire                KEY0,
    // cpu side of the bus
    input  wire addr_t         bus_address,
    input  wire data_t         bus_write_data,
    input  wire                bus_read_enable,
    input  wire                bus_write_enable,
    input  wire access_size_e  bus_read_type,
    input  wire access_size_e  bus_write_type,
    output data_t              bus_read_data,
    output logic               bus_read_done,
    output logic               bus_write_done,
    // keyboard
    input  wire byte_t         key_ascii,
    input  wire                key_pressed,
    input  wire                irq_ack,
    output irq_vec_t           irq_vector,
    // sd card controller
    input  wire byte_t         sd_dout,
    input  wire                sd_byte_available,
    input  wire                sd_ready,
    output logic               sd_rd_start,
    output sector_addr_t       sd_sector_addr
);

    // capture to buffer write port
    logic      buf_we;
    sd_index_t buf_waddr;
    byte_t     buf_wdata;
    // buffer read port, driven from the bus side
    sd_index_t buf_raddr;
    byte_t     buf_rdata;
    logic      sector_available;

    sd_sector_capture capture_inst (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .buf_we            (buf_we),
        .buf_waddr         (buf_waddr),
        .buf_wdata         (buf_wdata),
        .sector_available  (sector_available)
    );

    sd_sector_buffer buffer_inst (
        .CLOCK_50  (CLOCK_50),
        .buf_we    (buf_we),
        .buf_waddr (buf_waddr),
        .buf_wdata (buf_wdata),
        .buf_raddr (buf_raddr),
        .buf_rdata (buf_rdata)
    );

    bus_target target_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_type    (bus_read_type),
        .bus_write_type   (bus_write_type),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .key_ascii        (key_ascii),
        .key_pressed      (key_pressed),
        .irq_ack          (irq_ack),
        .irq_vector       (irq_vector),
        .sd_ready         (sd_ready),
        .sector_available (sector_available),
        .buf_raddr        (buf_raddr),
        .buf_rdata        (buf_rdata),
        .sd_rd_start      (sd_rd_start),
        .sd_sector_addr   (sd_sector_addr)
    );

endmodule

`default_nettype wire

//--- design/bus_target.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module bus_target
    import soc_pkg::*;
(
    input  wire                CLOCK_50,
    input  wire                KEY0,
    input  wire addr_t         bus_address,
    input  wire data_t         bus_write_data,
    input  wire                bus_read_enable,
    input  wire                bus_write_enable,
    input  wire access_size_e  bus_read_type,
    input  wire access_size_e  bus_write_type,
    output data_t              bus_read_data,
    output logic               bus_read_done,
    output logic               bus_write_done,
    input  wire byte_t         key_ascii,
    input  wire                key_pressed,
    input  wire                irq_ack,
    output irq_vec_t           irq_vector,
    input  wire                sd_ready,
    input  wire                sector_available,
    output sd_index_t          buf_raddr,
    input  wire byte_t         buf_rdata,
    output logic               sd_rd_start,
    output sector_addr_t       sd_sector_addr
);

    logic ram_sel, key_sel, addr_reg_sel, read_reg_sel, ready_sel, avail_sel, buf_sel;
    logic read_done_q, write_done_q;
    logic rd_pend, wr_pend;
    // RAM request and response
    logic         ram_start, ram_write, ram_done;
    access_size_e ram_size;
    data_t        ram_rdata;
    // one RAM access in flight, and whether it is a store
    logic ram_busy, ram_op_write;
    // last completed read came from RAM
    logic  ram_src;
    data_t reg_rdata, read_data_q;

    // address decode
    assign ram_sel = (bus_address >= addr_t'(`RAM_BASE))
        && (bus_address < addr_t'(`RAM_BASE + `RAM_WORDS * 4));
    assign key_sel      = (bus_address == addr_t'(`KEY_ADDR));
    assign addr_reg_sel = (bus_address == addr_t'(`SDC_ADDR_REG));
    assign read_reg_sel = (bus_address == addr_t'(`SDC_READ_REG));
    assign ready_sel    = (bus_address == addr_t'(`SDC_READY_REG));
    assign avail_sel    = (bus_address == addr_t'(`SDC_AVAIL_REG));
    assign buf_sel = (bus_address >= addr_t'(`SDC_BASE))
        && (bus_address < addr_t'(`SDC_BASE + `SDC_BYTES));
    assign buf_raddr = sd_index_t'(bus_address - addr_t'(`SDC_BASE));

    // enable dropped, done still low, so the access runs now
    assign rd_pend = !bus_read_enable && !read_done_q;
    assign wr_pend = !bus_write_enable && !write_done_q;

    // RAM handoff, request fields come straight off the bus
    assign ram_start = ram_sel && (rd_pend || wr_pend) && !ram_busy;
    assign ram_write = wr_pend;
    assign ram_size  = wr_pend ? bus_write_type : bus_read_type;

    // RAM completion shows up in the ram_done cycle itself
    assign bus_read_done  = read_done_q || (ram_done && !ram_op_write);
    assign bus_write_done = write_done_q || (ram_done && ram_op_write);
    assign bus_read_data  = ram_src ? ram_rdata : read_data_q;

    // register reads, zero for anything unmapped
    always_comb begin
        reg_rdata = '0;
        if (key_sel) reg_rdata = data_t'(key_ascii);
        else if (ready_sel) reg_rdata = data_t'(sd_ready);
        else if (avail_sel) reg_rdata = data_t'(sector_available);
        else if (buf_sel) reg_rdata = data_t'(buf_rdata);
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done_q    <= 1'b1;
            write_done_q   <= 1'b1;
            ram_busy       <= 1'b0;
            ram_op_write   <= 1'b0;
            ram_src        <= 1'b0;
            sd_rd_start    <= 1'b0;
            sd_sector_addr <= '0;
            irq_vector     <= '0;
        end else begin
            sd_rd_start <= 1'b0;
            if (ram_start) begin
                ram_busy     <= 1'b1;
                ram_op_write <= ram_write;
                ram_src      <= ram_src || !ram_write;
            end else if (ram_done) begin
                ram_busy <= 1'b0;
            end
            // read side
            if (bus_read_enable) read_done_q <= 1'b0;
            else if (ram_done && !ram_op_write) read_done_q <= 1'b1;
            else if (rd_pend && !ram_sel) begin
                read_done_q <= 1'b1;
                ram_src     <= 1'b0;
            end
            // write side
            if (bus_write_enable) write_done_q <= 1'b0;
            else if (ram_done && ram_op_write) write_done_q <= 1'b1;
            else if (wr_pend && !ram_sel) begin
                write_done_q <= 1'b1;
                if (addr_reg_sel) sd_sector_addr <= sector_addr_t'(bus_write_data[31:0]);
                if (read_reg_sel) sd_rd_start <= 1'b1;
            end
            // keyboard interrupt, ack has priority
            if (irq_ack && irq_vector != '0) irq_vector <= '0;
            else if (key_pressed && key_ascii != '0) irq_vector <= irq_vec_t'(`IRQ_KEY);
        end
    end

    // register read result
    always_ff @(posedge CLOCK_50) begin
        if (rd_pend && !ram_sel) read_data_q <= reg_rdata;
    end

    data_ram data_ram_inst (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ram_start (ram_start),
        .ram_write (ram_write),
        .ram_size  (ram_size),
        .ram_addr  (bus_address),
        .ram_wdata (bus_write_data),
        .ram_rdata (ram_rdata),
        .ram_done  (ram_done)
    );

endmodule

`default_nettype wire

//--- design/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module data_ram
    import soc_pkg::*;
(
    input  wire                CLOCK_50,
    input  wire                KEY0,
    input  wire                ram_start,
    input  wire                ram_write,
    input  wire access_size_e  ram_size,
    input  wire addr_t         ram_addr,
    input  wire data_t         ram_wdata,
    output data_t              ram_rdata,
    output logic               ram_done
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    // second state only used by doubleword accesses
    typedef enum logic {
        st_low,
        st_high
    } ram_state_e;

    word_t            ram_mem [0:`RAM_WORDS-1];
    ram_state_e       state;
    addr_t            offset;
    logic [IDX_W-1:0] word_idx;
    logic [IDX_W-1:0] high_idx;
    logic [1:0]       lane;

    // byte offset into the window, split into word and lane
    assign offset   = ram_addr - addr_t'(`RAM_BASE);
    assign word_idx = offset[IDX_W+1:2];
    assign lane     = offset[1:0];

    // sequencing and done pulse
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= st_low;
            ram_done <= 1'b0;
        end else begin
            ram_done <= 1'b0;
            case (state)
                st_low: begin
                    if (ram_start) begin
                        // doubleword needs a second cycle for the upper word
                        if (ram_size == size_d) begin
                            state <= st_high;
                        end else begin
                            ram_done <= 1'b1;
                        end
                    end
                end
                st_high: begin
                    state    <= st_low;
                    ram_done <= 1'b1;
                end
                default: state <= st_low;
            endcase
        end
    end

    // storage and read data
    always_ff @(posedge CLOCK_50) begin
        if (ram_start) begin
            high_idx <= word_idx + 1'b1;
            if (ram_write) begin
                case (ram_size)
                    size_b, size_bu: ram_mem[word_idx][{lane, 3'b000} +: 8] <= ram_wdata[7:0];
                    // halves land on offset 0 or 2 only
                    size_h, size_hu: begin
                        ram_mem[word_idx][{lane[1], 4'b0000} +: 16] <= ram_wdata[15:0];
                    end
                    // word, and low word of a doubleword
                    default: ram_mem[word_idx] <= ram_wdata[31:0];
                endcase
            end else if (ram_size == size_d) begin
                ram_rdata[31:0] <= ram_mem[word_idx];
            end else begin
                // shifted down by the offset, no sign extension here
                ram_rdata <= {32'b0, ram_mem[word_idx] >> {lane, 3'b000}};
            end
        end
        // upper word of a doubleword, next word address
        if (state == st_high) begin
            if (ram_write) begin
                ram_mem[high_idx] <= ram_wdata[63:32];
            end else begin
                ram_rdata[63:32] <= ram_mem[high_idx];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sd_sector_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module sd_sector_buffer
    import soc_pkg::*;
(
    input  wire             CLOCK_50,
    // write port from the capture side
    input  wire             buf_we,
    input  wire sd_index_t  buf_waddr,
    input  wire byte_t      buf_wdata,
    // read port from the bus side
    input  wire sd_index_t  buf_raddr,
    output byte_t           buf_rdata
);

    // one sector of bytes
    byte_t sector_mem [0:`SDC_BYTES-1];

    always_ff @(posedge CLOCK_50) begin
        if (buf_we) begin
            sector_mem[buf_waddr] <= buf_wdata;
        end
    end

    // bus reads see the byte in the same cycle
    assign buf_rdata = sector_mem[buf_raddr];

endmodule

`default_nettype wire

//--- design/sd_sector_capture.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module sd_sector_capture
    import soc_pkg::*;
(
    input  wire         CLOCK_50,
    input  wire         KEY0,
    input  wire byte_t  sd_dout,
    input  wire         sd_byte_available,
    output logic        buf_we,
    output sd_index_t   buf_waddr,
    output byte_t       buf_wdata,
    output logic        sector_available
);

    // byte strobe one cycle back, for the rising edge
    logic      strobe_d;
    // next free slot in the sector, wraps after the last byte
    sd_index_t byte_index;

    // one buffer write per strobe edge, in the edge cycle itself
    assign buf_we    = sd_byte_available && !strobe_d;
    assign buf_waddr = byte_index;
    assign buf_wdata = sd_dout;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            strobe_d         <= 1'b0;
            byte_index       <= '0;
            sector_available <= 1'b0;
        end else begin
            strobe_d <= sd_byte_available;
            if (buf_we) begin
                byte_index <= byte_index + 1'b1;
                // last byte of the sector just went in
                if (byte_index == sd_index_t'(`SDC_BYTES - 1)) begin
                    sector_available <= 1'b1;
                // first byte of a new sector, old one is being overwritten
                end else if (byte_index == '0) begin
                    sector_available <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // bus byte address and data
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    // one RAM word
    typedef logic [31:0] word_t;
    // sd byte, ascii code, RAM byte lane
    typedef logic [7:0]  byte_t;
    // position inside a 512-byte sector
    typedef logic [8:0]  sd_index_t;
    typedef logic [31:0] sector_addr_t;
    typedef logic [3:0]  irq_vec_t;

    // low two bits give the width, bit 2 marks unsigned
    typedef enum logic [2:0] {
        size_b  = 3'b000,
        size_h  = 3'b001,
        size_w  = 3'b010,
        size_d  = 3'b011,
        size_bu = 3'b100,
        size_hu = 3'b101,
        size_wu = 3'b110
    } access_size_e;

endpackage

`default_nettype wire

//--- design/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// word RAM window
`define RAM_BASE      32'h0000_1000
// depth in 32-bit words, 4 KB in all
`define RAM_WORDS     1024

// keyboard ascii byte, read only
`define KEY_ADDR      32'h0000_2000

// sd card control and status registers
// sector number for the next read, write only
`define SDC_ADDR_REG  32'h0000_2010
// any write here starts a sector read
`define SDC_READ_REG  32'h0000_2014
// card ready bit
`define SDC_READY_REG 32'h0000_2018
// full sector sitting in the buffer
`define SDC_AVAIL_REG 32'h0000_201C

// sector buffer window, one byte per address
`define SDC_BASE      32'h0000_3000
`define SDC_BYTES     512

// interrupt vector raised on a key press
`define IRQ_KEY       4'd1

`endif
